/* src/addrgen_pkg.sv */
// Address generator package with widths, command opcodes and shared payload structs
`default_nettype none

package addrgen_pkg;

	// ==============================
	// Sizes
	// ==============================
	// Vector dimensions per work item
	localparam int VDIM   = 2;
	// Array dimensions
	localparam int DIM    = 3;
	localparam int WBW    = 16;
	localparam int ABW    = 32;
	// Stride fraction and shift widths
	localparam int SF_BW  = 4;
	localparam int SS_BW  = 3;
	localparam int N_CFG  = 4;
	localparam int ID_BW  = 2;
	// Shuffle index selects one of DIM dimensions
	localparam int DIM_BW = 2;

	// ==============================
	// Command encoding
	// ==============================
	typedef enum logic [2:0] {
		OP_SET_BSTRIDE = 3'd0,
		OP_SET_ASTRIDE = 3'd1,
		OP_SET_SHUF    = 3'd2,
		OP_SET_BOUND   = 3'd3,
		OP_SET_BASE    = 3'd4,
		OP_ISSUE       = 3'd5
	} opcode_e;

	// One offset per vector dimension
	typedef logic [VDIM-1:0][WBW-1:0] ofs_vec_t;

	// Set commands carry field values in bofs/aofs
	// Wide fields (bound, base) read bofs as one ABW word
	typedef struct packed {
		opcode_e           op;
		logic [ID_BW-1:0]  id;
		logic [DIM_BW-1:0] dim;
		ofs_vec_t          bofs;
		ofs_vec_t          aofs;
		logic              retire;
		logic              islast;
	} cmd_t;

	// ==============================
	// Payloads
	// ==============================
	typedef struct packed {
		logic [VDIM-1:0][SF_BW-1:0]  bfrac;
		logic [VDIM-1:0][SS_BW-1:0]  bshamt;
		logic [VDIM-1:0][SF_BW-1:0]  afrac;
		logic [VDIM-1:0][SS_BW-1:0]  ashamt;
		logic [VDIM-1:0][DIM_BW-1:0] bshuf;
		logic [VDIM-1:0][DIM_BW-1:0] ashuf;
		logic [DIM-1:0][ABW-1:0]     bound;
		logic [ABW-1:0]              base;
	} cfg_t;

	// Work item joined with its configuration
	typedef struct packed {
		logic [ID_BW-1:0] id;
		ofs_vec_t         bofs;
		ofs_vec_t         aofs;
		logic             retire;
		logic             islast;
		cfg_t             cfg;
	} work_t;

	typedef struct packed {
		logic [ID_BW-1:0] id;
		logic [ABW-1:0]   linear;
		ofs_vec_t         bofs;
		logic             retire;
		logic             islast;
	} addr_t;

endpackage

`default_nettype wire

/* src/rdyack_fwd.sv */
// Forward slot holding one rdy/ack register stage with a packed payload
`default_nettype none

module rdyack_fwd #(
	parameter int PBW = 8
) (
	input  wire logic           i_clk,
	input  wire logic           i_rst_n,
	input  wire logic           i_src_rdy,
	output logic                o_src_ack,
	input  wire logic [PBW-1:0] i_src_data,
	output logic                o_dst_rdy,
	input  wire logic           i_dst_ack,
	output logic [PBW-1:0]      o_dst_data
);

	logic           full_r;
	logic [PBW-1:0] data_r;

	// Take a new item when empty or when the current one leaves this cycle
	assign o_src_ack  = i_src_rdy && (!full_r || i_dst_ack);
	assign o_dst_rdy  = full_r;
	assign o_dst_data = data_r;

	// ==============================
	// Occupancy
	// ==============================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			full_r <= 1'b0;
		end else if (o_src_ack) begin
			// Refill also covers the drain-and-load case
			full_r <= 1'b1;
		end else if (i_dst_ack) begin
			full_r <= 1'b0;
		end
	end

	// Payload held while downstream stalls
	always_ff @(posedge i_clk) begin
		if (o_src_ack) begin
			data_r <= i_src_data;
		end
	end

endmodule

`default_nettype wire

/* src/nd_shuf_accum.sv */
// Shuffle accumulator that scatters two offset vectors into N-D dimensions and sums them
`default_nettype none

module nd_shuf_accum #(
	parameter int BW      = 16,
	parameter int DIM_IN  = 2,
	parameter int DIM_OUT = 3,
	localparam int SBW    = (DIM_OUT > 1) ? $clog2(DIM_OUT) : 1
) (
	input  wire logic [DIM_IN-1:0][BW-1:0]  i_addend1,
	input  wire logic [DIM_IN-1:0][BW-1:0]  i_addend2,
	input  wire logic [DIM_IN-1:0][SBW-1:0] i_shuf1,
	input  wire logic [DIM_IN-1:0][SBW-1:0] i_shuf2,
	output logic [DIM_OUT-1:0][BW-1:0]      o_sum
);

	// ==============================
	// Scatter and sum
	// ==============================
	// Colliding lanes add up in the same dimension
	// Dimension with no selecting lane stays zero
	always_comb begin
		for (int d = 0; d < DIM_OUT; d++) begin
			o_sum[d] = '0;
			for (int i = 0; i < DIM_IN; i++) begin
				if (i_shuf1[i] == SBW'(d)) begin
					o_sum[d] = o_sum[d] + i_addend1[i];
				end
				// Second vector uses its own index table
				if (i_shuf2[i] == SBW'(d)) begin
					o_sum[d] = o_sum[d] + i_addend2[i];
				end
			end
		end
	end

endmodule

`default_nettype wire

/* src/cmd_decode.sv */
// Command decoder that updates configuration slots and emits work items with their config
`default_nettype none

module cmd_decode #(
	parameter int N_CFG = addrgen_pkg::N_CFG
) (
	input  wire logic                i_clk,
	input  wire logic                i_rst_n,
	input  wire logic                i_cmd_rdy,
	output logic                     o_cmd_ack,
	input  wire addrgen_pkg::cmd_t   i_cmd,
	output logic                     o_work_rdy,
	input  wire logic                i_work_ack,
	output addrgen_pkg::work_t       o_work
);

	import addrgen_pkg::*;

	// Configuration slots indexed by command id
	cfg_t  cfg_r [N_CFG];
	work_t work_w;
	logic  is_issue;
	logic  issue_rdy;
	logic  issue_ack;

	// ==============================
	// Handshake
	// ==============================
	assign is_issue  = (i_cmd.op == OP_ISSUE);
	assign issue_rdy = i_cmd_rdy && is_issue;
	// Set commands never wait on the pipeline
	assign o_cmd_ack = is_issue ? issue_ack : i_cmd_rdy;

	// ==============================
	// Slot writes
	// ==============================
	always_ff @(posedge i_clk) begin
		if (i_cmd_rdy && !is_issue) begin
			case (i_cmd.op)
				// Fraction from bofs lane and shift from aofs lane
				OP_SET_BSTRIDE: begin
					for (int v = 0; v < VDIM; v++) begin
						cfg_r[i_cmd.id].bfrac[v]  <= i_cmd.bofs[v][SF_BW-1:0];
						cfg_r[i_cmd.id].bshamt[v] <= i_cmd.aofs[v][SS_BW-1:0];
					end
				end
				OP_SET_ASTRIDE: begin
					for (int v = 0; v < VDIM; v++) begin
						cfg_r[i_cmd.id].afrac[v]  <= i_cmd.bofs[v][SF_BW-1:0];
						cfg_r[i_cmd.id].ashamt[v] <= i_cmd.aofs[v][SS_BW-1:0];
					end
				end
				// b shuffle from bofs and a shuffle from aofs
				OP_SET_SHUF: begin
					for (int v = 0; v < VDIM; v++) begin
						cfg_r[i_cmd.id].bshuf[v] <= i_cmd.bofs[v][DIM_BW-1:0];
						cfg_r[i_cmd.id].ashuf[v] <= i_cmd.aofs[v][DIM_BW-1:0];
					end
				end
				// Index beyond DIM is dropped
				OP_SET_BOUND: begin
					if (int'(i_cmd.dim) < DIM) begin
						cfg_r[i_cmd.id].bound[i_cmd.dim] <= ABW'(i_cmd.bofs);
					end
				end
				OP_SET_BASE: begin
					cfg_r[i_cmd.id].base <= ABW'(i_cmd.bofs);
				end
				default: begin
				end
			endcase
		end
	end

	// ==============================
	// Issue path
	// ==============================
	// Join offsets with the current slot contents
	always_comb begin
		work_w.id     = i_cmd.id;
		work_w.bofs   = i_cmd.bofs;
		work_w.aofs   = i_cmd.aofs;
		work_w.retire = i_cmd.retire;
		work_w.islast = i_cmd.islast;
		work_w.cfg    = cfg_r[i_cmd.id];
	end

	rdyack_fwd #(.PBW($bits(work_t))) u_issue_fwd (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_src_rdy  (issue_rdy),
		.o_src_ack  (issue_ack),
		.i_src_data (work_w),
		.o_dst_rdy  (o_work_rdy),
		.i_dst_ack  (i_work_ack),
		.o_dst_data (o_work)
	);

endmodule

`default_nettype wire

/* src/memofs_stage.sv */
// Memory offset stage that scales, shuffles and accumulates offsets, then linearizes them
`default_nettype none

module memofs_stage (
	input  wire logic               i_clk,
	input  wire logic               i_rst_n,
	input  wire logic               i_src_rdy,
	output logic                    o_src_ack,
	input  wire addrgen_pkg::work_t i_src,
	output logic                    o_dst_rdy,
	input  wire logic               i_dst_ack,
	output addrgen_pkg::addr_t      o_dst
);

	import addrgen_pkg::*;

	// Stage 0 payload with N-D offsets plus what stage 1 needs
	typedef struct packed {
		logic [ID_BW-1:0]        id;
		logic [DIM-1:0][WBW-1:0] mofs;
		logic [DIM-2:0][ABW-1:0] mult;
		logic [ABW-1:0]          base;
		ofs_vec_t                bofs;
		logic                    retire;
		logic                    islast;
	} s0_t;

	ofs_vec_t                bofs_stride;
	ofs_vec_t                aofs_stride;
	logic [DIM-1:0][WBW-1:0] mofs_w;
	s0_t                     s0_w;
	s0_t                     s0_r;
	logic                    s0_rdy;
	logic                    s0_ack;
	logic [ABW-1:0]          linear_w;
	addr_t                   addr_w;

	// ==============================
	// Stage 0
	// ==============================
	// Offset times frac shifted left by shamt and kept to WBW
	always_comb begin
		for (int v = 0; v < VDIM; v++) begin
			bofs_stride[v] = (i_src.bofs[v] * WBW'(i_src.cfg.bfrac[v])) << i_src.cfg.bshamt[v];
			aofs_stride[v] = (i_src.aofs[v] * WBW'(i_src.cfg.afrac[v])) << i_src.cfg.ashamt[v];
		end
	end

	nd_shuf_accum #(.BW(WBW), .DIM_IN(VDIM), .DIM_OUT(DIM)) u_saccum (
		.i_addend1 (bofs_stride),
		.i_addend2 (aofs_stride),
		.i_shuf1   (i_src.cfg.bshuf),
		.i_shuf2   (i_src.cfg.ashuf),
		.o_sum     (mofs_w)
	);

	always_comb begin
		s0_w.id   = i_src.id;
		s0_w.mofs = mofs_w;
		// Multipliers are boundaries 1..DIM-1
		for (int d = 0; d < DIM-1; d++) begin
			s0_w.mult[d] = i_src.cfg.bound[d+1];
		end
		s0_w.base   = i_src.cfg.base;
		s0_w.bofs   = i_src.bofs;
		s0_w.retire = i_src.retire;
		s0_w.islast = i_src.islast;
	end

	rdyack_fwd #(.PBW($bits(s0_t))) u_fwd0 (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_src_rdy  (i_src_rdy),
		.o_src_ack  (o_src_ack),
		.i_src_data (s0_w),
		.o_dst_rdy  (s0_rdy),
		.i_dst_ack  (s0_ack),
		.o_dst_data (s0_r)
	);

	// ==============================
	// Stage 1
	// ==============================
	// Base plus last offset plus each mofs[d] * mult[d] wrapping at ABW
	always_comb begin
		linear_w = s0_r.base + ABW'(s0_r.mofs[DIM-1]);
		for (int d = 0; d < DIM-1; d++) begin
			linear_w = linear_w + ABW'(s0_r.mofs[d]) * s0_r.mult[d];
		end
	end

	always_comb begin
		addr_w.id     = s0_r.id;
		addr_w.linear = linear_w;
		addr_w.bofs   = s0_r.bofs;
		addr_w.retire = s0_r.retire;
		addr_w.islast = s0_r.islast;
	end

	rdyack_fwd #(.PBW($bits(addr_t))) u_fwd1 (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_src_rdy  (s0_rdy),
		.o_src_ack  (s0_ack),
		.i_src_data (addr_w),
		.o_dst_rdy  (o_dst_rdy),
		.i_dst_ack  (i_dst_ack),
		.o_dst_data (o_dst)
	);

endmodule

`default_nettype wire

/* src/result_collector.sv */
// Result collector with output register, retire count and per-config done pulse
`default_nettype none

module result_collector #(
	parameter int CNT_BW = 16
) (
	input  wire logic                      i_clk,
	input  wire logic                      i_rst_n,
	input  wire logic                      i_src_rdy,
	output logic                           o_src_ack,
	input  wire addrgen_pkg::addr_t        i_src,
	output logic                           o_dst_rdy,
	input  wire logic                      i_dst_ack,
	output addrgen_pkg::addr_t             o_dst,
	output logic                           o_done,
	output logic [addrgen_pkg::ID_BW-1:0]  o_done_id,
	output logic [CNT_BW-1:0]              o_retire_cnt
);

	import addrgen_pkg::*;

	logic dst_xfer;

	rdyack_fwd #(.PBW($bits(addr_t))) u_out_fwd (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_src_rdy  (i_src_rdy),
		.o_src_ack  (o_src_ack),
		.i_src_data (i_src),
		.o_dst_rdy  (o_dst_rdy),
		.i_dst_ack  (i_dst_ack),
		.o_dst_data (o_dst)
	);

	// Record leaves only when both sides agree
	assign dst_xfer = o_dst_rdy && i_dst_ack;

	// ==============================
	// Retire count and done
	// ==============================
	always_ff @(posedge i_clk) begin
		if (!i_rst_n) begin
			o_retire_cnt <= '0;
			o_done       <= 1'b0;
		end else begin
			if (dst_xfer && o_dst.retire) begin
				o_retire_cnt <= o_retire_cnt + 1'b1;
			end
			// One-cycle pulse right after the last record goes out
			o_done <= dst_xfer && o_dst.islast;
		end
	end

	// Id of the finishing configuration
	always_ff @(posedge i_clk) begin
		if (dst_xfer) begin
			o_done_id <= o_dst.id;
		end
	end

endmodule

`default_nettype wire

/* src/addrgen_top.sv */
// Address generator top that chains command decode, offset pipeline and result collector
`default_nettype none

module addrgen_top #(
	parameter int N_CFG  = addrgen_pkg::N_CFG,
	parameter int CNT_BW = 16
) (
	input  wire logic                     i_clk,
	input  wire logic                     i_rst_n,
	input  wire logic                     i_cmd_rdy,
	output logic                          o_cmd_ack,
	input  wire addrgen_pkg::cmd_t        i_cmd,
	output logic                          o_addr_rdy,
	input  wire logic                     i_addr_ack,
	output addrgen_pkg::addr_t            o_addr,
	output logic                          o_done,
	output logic [addrgen_pkg::ID_BW-1:0] o_done_id,
	output logic [CNT_BW-1:0]             o_retire_cnt
);

	import addrgen_pkg::*;

	// ==============================
	// Inter-stage links
	// ==============================
	logic  work_rdy;
	logic  work_ack;
	work_t work;
	logic  res_rdy;
	logic  res_ack;
	addr_t res;

	// Decode with one slot
	cmd_decode #(.N_CFG(N_CFG)) u_decode (
		.i_clk      (i_clk),
		.i_rst_n    (i_rst_n),
		.i_cmd_rdy  (i_cmd_rdy),
		.o_cmd_ack  (o_cmd_ack),
		.i_cmd      (i_cmd),
		.o_work_rdy (work_rdy),
		.i_work_ack (work_ack),
		.o_work     (work)
	);

	// Execute with two slots
	memofs_stage u_memofs (
		.i_clk     (i_clk),
		.i_rst_n   (i_rst_n),
		.i_src_rdy (work_rdy),
		.o_src_ack (work_ack),
		.i_src     (work),
		.o_dst_rdy (res_rdy),
		.i_dst_ack (res_ack),
		.o_dst     (res)
	);

	// Result with one slot
	result_collector #(.CNT_BW(CNT_BW)) u_result (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_src_rdy    (res_rdy),
		.o_src_ack    (res_ack),
		.i_src        (res),
		.o_dst_rdy    (o_addr_rdy),
		.i_dst_ack    (i_addr_ack),
		.o_dst        (o_addr),
		.o_done       (o_done),
		.o_done_id    (o_done_id),
		.o_retire_cnt (o_retire_cnt)
	);

endmodule

`default_nettype wire

/* sim/tb_addrgen.sv */
// Address generator testbench that replays commands from a data file and checks every result
`default_nettype none

module tb_addrgen;

	import addrgen_pkg::*;

	// ==============================
	// Limits and DUT signals
	// ==============================
	localparam int CMD_TIMEOUT   = 200;
	localparam int DRAIN_TIMEOUT = 4000;
	// Edges from issue acceptance to first record transfer with ack held high
	localparam int LATENCY       = 4;

	logic             i_clk;
	logic             i_rst_n;
	logic             i_cmd_rdy;
	logic             o_cmd_ack;
	cmd_t             i_cmd;
	logic             o_addr_rdy;
	logic             i_addr_ack;
	addr_t            o_addr;
	logic             o_done;
	logic [ID_BW-1:0] o_done_id;
	logic [15:0]      o_retire_cnt;

	// Scoreboard queues filled at issue time and drained at output transfer
	addr_t            exp_q[$];
	int               issue_q[$];
	logic             lat_q[$];
	int               cycle        = 0;
	int               errors       = 0;
	int               retire_exp   = 0;
	int               tests_run    = 0;
	int               tests_failed = 0;
	logic             pend_done    = 1'b0;
	logic [ID_BW-1:0] pend_id      = '0;
	// Stops reading the data file after a timeout
	logic             aborted      = 1'b0;
	// Output ack held high instead of random
	logic             ack_hi       = 1'b0;
	int               seed         = 70212;

	addrgen_top #(.N_CFG(N_CFG), .CNT_BW(16)) i_dut (
		.i_clk        (i_clk),
		.i_rst_n      (i_rst_n),
		.i_cmd_rdy    (i_cmd_rdy),
		.o_cmd_ack    (o_cmd_ack),
		.i_cmd        (i_cmd),
		.o_addr_rdy   (o_addr_rdy),
		.i_addr_ack   (i_addr_ack),
		.o_addr       (o_addr),
		.o_done       (o_done),
		.o_done_id    (o_done_id),
		.o_retire_cnt (o_retire_cnt)
	);

	initial begin
		i_clk = 1'b0;
		forever #50 i_clk = ~i_clk;
	end

	// ==============================
	// Helpers
	// ==============================
	function automatic string test_name(input int num);
		case (num)
			0: return "reset state";
			1: return "configuration and linearization";
			2: return "shuffle collisions";
			3: return "separate configurations";
			4: return "order and back-pressure";
			5: return "retire and done";
			6: return "latency";
			default: return "unnamed";
		endcase
	endfunction

	task automatic check_field(input string name, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got === exp) else begin
			$display("Mismatch %s: got %h expected %h", name, got, exp);
			errors++;
		end
	endtask

	task automatic compare_record(input addr_t exp);
		check_field("o_addr.id", 32'(o_addr.id), 32'(exp.id));
		check_field("o_addr.linear", o_addr.linear, exp.linear);
		check_field("o_addr.bofs", 32'(o_addr.bofs), 32'(exp.bofs));
		check_field("o_addr.retire", 32'(o_addr.retire), 32'(exp.retire));
		check_field("o_addr.islast", 32'(o_addr.islast), 32'(exp.islast));
	endtask

	task automatic abort_run(input string why);
		errors++;
		aborted = 1'b1;
		$display("%s", why);
	endtask

	task automatic report_test(input int num, input int err0);
		tests_run++;
		if (errors != err0) begin
			tests_failed++;
		end
		$display("Test %0d %s: %s (%0d errors)", num, test_name(num),
			(errors == err0) ? "pass" : "fail", errors - err0);
	endtask

	// Hold the command until the DUT takes it
	task automatic send_cmd(input cmd_t cmd);
		int n;
		n = 0;
		i_cmd     <= cmd;
		i_cmd_rdy <= 1'b1;
		do begin
			@(posedge i_clk);
			n++;
		end while (!o_cmd_ack && n < CMD_TIMEOUT);
		if (!o_cmd_ack) begin
			abort_run("Timeout waiting for o_cmd_ack");
		end
	endtask

	// Wait for all expected records and the last done pulse
	task automatic drain_results();
		int n;
		n = 0;
		i_cmd_rdy <= 1'b0;
		while ((exp_q.size() != 0 || pend_done) && n < DRAIN_TIMEOUT) begin
			@(posedge i_clk);
			n++;
		end
		if (exp_q.size() != 0 || pend_done) begin
			abort_run("Timeout waiting for expected records on o_addr");
		end else begin
			// Counter settles one edge after the last transfer
			@(posedge i_clk);
			check_field("o_retire_cnt", 32'(o_retire_cnt), 32'(retire_exp));
		end
	endtask

	task automatic verify_reset();
		int err0;
		err0 = errors;
		check_field("o_addr_rdy", 32'(o_addr_rdy), 32'd0);
		check_field("o_cmd_ack", 32'(o_cmd_ack), 32'd0);
		check_field("o_done", 32'(o_done), 32'd0);
		check_field("o_retire_cnt", 32'(o_retire_cnt), 32'd0);
		report_test(0, err0);
	endtask

	// ==============================
	// Data file parsing
	// ==============================
	// Command columns are op id dim bofs0 bofs1 aofs0 aofs1 retire islast
	task automatic read_command(input int fd, output cmd_t cmd);
		logic [31:0] fld [9];
		int          rc;
		rc = $fscanf(fd, "%h %h %h %h %h %h %h %h %h", fld[0], fld[1], fld[2],
			fld[3], fld[4], fld[5], fld[6], fld[7], fld[8]);
		assert (rc == 9) else begin
			$display("Malformed command line in data file");
			errors++;
		end
		cmd.op      = opcode_e'(fld[0][2:0]);
		cmd.id      = fld[1][ID_BW-1:0];
		cmd.dim     = fld[2][DIM_BW-1:0];
		cmd.bofs[0] = fld[3][WBW-1:0];
		cmd.bofs[1] = fld[4][WBW-1:0];
		cmd.aofs[0] = fld[5][WBW-1:0];
		cmd.aofs[1] = fld[6][WBW-1:0];
		cmd.retire  = fld[7][0];
		cmd.islast  = fld[8][0];
	endtask

	// Expect columns are id linear bofs0 bofs1 retire islast
	task automatic read_expect(input int fd, output addr_t rec);
		logic [31:0] fld [6];
		int          rc;
		rc = $fscanf(fd, "%h %h %h %h %h %h", fld[0], fld[1], fld[2],
			fld[3], fld[4], fld[5]);
		assert (rc == 6) else begin
			$display("Malformed expect line in data file");
			errors++;
		end
		rec.id      = fld[0][ID_BW-1:0];
		rec.linear  = fld[1];
		rec.bofs[0] = fld[2][WBW-1:0];
		rec.bofs[1] = fld[3][WBW-1:0];
		rec.retire  = fld[4][0];
		rec.islast  = fld[5][0];
	endtask

	task automatic run_tests(input int fd);
		cmd_t          cmd;
		addr_t         rec;
		logic [7:0]    tag;
		logic [1023:0] skip_line;
		int            rc;
		int            tnum;
		int            mode;
		int            err0;
		tnum = 0;
		err0 = errors;
		while (!aborted && $fscanf(fd, " %c", tag) == 1) begin
			case (tag)
				"#": rc = $fgets(skip_line, fd);
				"T": begin
					rc   = $fscanf(fd, "%d", tnum);
					err0 = errors;
				end
				"A": begin
					rc     = $fscanf(fd, "%d", mode);
					ack_hi = (mode != 0);
				end
				"C": begin
					read_command(fd, cmd);
					send_cmd(cmd);
				end
				"E": begin
					read_expect(fd, rec);
					exp_q.push_back(rec);
				end
				"W": begin
					drain_results();
					report_test(tnum, err0);
				end
				default: begin
					$display("Unknown line tag %c in data file", tag);
					errors++;
				end
			endcase
		end
	endtask

	task automatic finish_run();
		assert (tests_run > 1) else begin
			$display("No tests were read from the data file");
			errors++;
		end
		$display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, errors);
		if (errors == 0 && tests_failed == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	endtask

	// ==============================
	// Output side
	// ==============================
	// Ack is random or held high per test
	always @(posedge i_clk) begin
		int rnd;
		if (ack_hi) begin
			i_addr_ack <= 1'b1;
		end else begin
			rnd = $random(seed);
			i_addr_ack <= rnd[0];
		end
	end

	// Tracks issues, checks records, latency and the done pulse
	always @(posedge i_clk) begin
		addr_t exp_rec;
		int    issued_at;
		logic  timed;
		cycle++;
		if (i_rst_n) begin
			// Done only on the edge right after an islast transfer
			check_field("o_done", 32'(o_done), 32'(pend_done));
			if (pend_done && o_done) begin
				check_field("o_done_id", 32'(o_done_id), 32'(pend_id));
			end
			pend_done = 1'b0;
			if (i_cmd_rdy && o_cmd_ack && i_cmd.op == OP_ISSUE) begin
				issue_q.push_back(cycle);
				lat_q.push_back(ack_hi);
			end
			if (o_addr_rdy && i_addr_ack) begin
				assert (exp_q.size() > 0 && issue_q.size() > 0) else begin
					$display("Unexpected record on o_addr with no issue pending");
					errors++;
				end
				if (exp_q.size() > 0 && issue_q.size() > 0) begin
					exp_rec   = exp_q.pop_front();
					issued_at = issue_q.pop_front();
					timed     = lat_q.pop_front();
					compare_record(exp_rec);
					if (timed) begin
						check_field("o_addr_rdy latency", 32'(cycle - issued_at),
							32'(LATENCY));
					end
					if (exp_rec.retire) begin
						retire_exp++;
					end
					pend_done = exp_rec.islast;
					pend_id   = exp_rec.id;
				end
			end
		end
	end

	// ==============================
	// Main sequence
	// ==============================
	initial begin
		int fd;
		i_rst_n    <= 1'b0;
		i_cmd_rdy  <= 1'b0;
		i_cmd      <= '0;
		// Idle command sits on the issue path so the reset check sees the slot ack
		i_cmd.op   <= OP_ISSUE;
		i_addr_ack <= 1'b0;
		repeat (5) @(posedge i_clk);
		i_rst_n <= 1'b1;
		@(posedge i_clk);
		verify_reset();
		fd = $fopen("sim/addrgen_testdata.txt", "r");
		if (fd == 0) begin
			abort_run("Cannot open sim/addrgen_testdata.txt");
		end else begin
			run_tests(fd);
			$fclose(fd);
		end
		finish_run();
	end

endmodule

`default_nettype wire

/* sim/addrgen_testdata.txt */
# C op id dim bofs0 bofs1 aofs0 aofs1 retire islast (hex); E id linear bofs0 bofs1 retire islast
# T test number, A ack mode (1 held high, 0 random), W wait for results and report
T 1
A 1
C 0 0 0 3 1 1 0 0 0
C 1 0 0 1 2 0 2 0 0
C 2 0 0 0 1 2 3 0 0
C 3 0 1 40 0 0 0 0 0
C 3 0 2 10 0 0 0 0 0
C 4 0 0 0 1 0 0 0 0
C 5 0 0 5 7 9 0 1 0
E 0 000107f9 5 7 1 0
W
T 2
C 0 1 0 1 2 0 1 0 0
C 1 1 0 1 1 2 0 0 0
C 2 1 0 1 1 1 3 0 0
C 3 1 1 100 0 0 0 0 0
C 3 1 2 20 0 0 0 0 0
C 4 1 0 0 20 0 0 0 0
C 5 1 0 3 4 2 55 1 0
E 1 00200360 3 4 1 0
W
T 3
C 5 0 0 1 2 3 0 0 0
E 0 000101a3 1 2 0 0
C 5 1 0 1 2 3 0 0 0
E 1 002002a0 1 2 0 0
C 4 0 0 0 3 0 0 0 0
C 5 0 0 1 2 3 0 0 0
E 0 000301a3 1 2 0 0
W
T 4
A 0
C 5 0 0 0 0 0 0 1 0
E 0 00030000 0 0 1 0
C 5 1 0 2 0 0 0 0 0
E 1 00200040 2 0 0 0
C 5 0 0 0 1 0 0 1 0
E 0 00030010 0 1 1 0
C 5 0 0 1 0 0 0 0 0
E 0 00030180 1 0 0 0
C 5 1 0 0 1 1 0 1 0
E 1 00200100 0 1 1 0
C 5 0 0 0 0 4 0 1 0
E 0 00030004 0 0 1 0
W
T 5
C 5 0 0 2 0 0 0 1 0
E 0 00030300 2 0 1 0
C 5 1 0 0 0 0 0 1 1
E 1 00200000 0 0 1 1
C 5 0 0 0 0 0 0 0 1
E 0 00030000 0 0 0 1
W
T 6
A 1
C 5 0 0 5 7 9 0 1 0
E 0 000307f9 5 7 1 0
C 5 1 0 3 4 2 55 0 0
E 1 00200360 3 4 0 0
W

/* build.f */
src/addrgen_pkg.sv
src/rdyack_fwd.sv
src/nd_shuf_accum.sv
src/cmd_decode.sv
src/memofs_stage.sv
src/result_collector.sv
src/addrgen_top.sv
sim/tb_addrgen.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_addrgen -f build.f \
	> build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/Vtb_addrgen > sim.log 2>&1
cat sim.log
grep -q "Done: errors found" sim.log && exit 1
grep -q "Done: no errors" sim.log || exit 1
